// ==== fxpFmtPkg.sv ====
package fxpFmtPkg;

    // Signed fixed-point coefficient width
    localparam int COEFF_WIDTH = 16;

    // Half-sum and LUT entry width, holds the full 24-tap range
    localparam int ACC_WIDTH = 22;

    // Output word width, offset binary
    localparam int OUT_WIDTH = 12;

    // Arithmetic right shift applied to the total before saturation
    localparam int OUT_SHIFT = 8;

    // Added before the shift for round-half-up
    localparam int ROUND_BIAS = 1 << (OUT_SHIFT - 1);

    // Output validity while the window fills after reset
    typedef enum logic {
        FILLING,
        RUNNING
    } fillState_e;

endpackage

// ==== firGeomPkg.sv ====
package firGeomPkg;

    // Input bits per output word
    localparam int DSR = 4;

    // Taps on each side of the window centre
    localparam int LOOKAHEAD = 12;
    localparam int LOOKBACK = 12;
    localparam int LOOKTOTAL = LOOKAHEAD + LOOKBACK;

    // Frames until every window bit holds a real sample
    localparam int FRAMES_TO_FILL = LOOKTOTAL / DSR;

    // Address bits per LUT
    localparam int LUT_BITS = 6;

    // Clocks from a frame strobe to the matching output word
    localparam int PIPE_FRAMES = 4;

    // Lookahead taps, index 0 next to the centre
    localparam logic signed [fxpFmtPkg::COEFF_WIDTH-1:0] HB [LOOKAHEAD] = '{
        16'sd32000,
        16'sd31000,
        16'sd29500,
        16'sd27500,
        16'sd25500,
        16'sd23500,
        16'sd21500,
        16'sd19500,
        16'sd17500,
        16'sd15500,
        16'sd13500,
        16'sd11500
    };

    // Lookback taps, index 0 next to the centre
    // Total of both tables sits just above full scale, so a constant
    // stream clips while a lone impulse stays inside the range
    localparam logic signed [fxpFmtPkg::COEFF_WIDTH-1:0] HF [LOOKBACK] = '{
        16'sd31500,
        16'sd30200,
        16'sd28800,
        16'sd27000,
        16'sd25000,
        16'sd23000,
        16'sd21000,
        16'sd19000,
        16'sd17000,
        16'sd15000,
        16'sd13000,
        16'sd11000
    };

endpackage

// ==== sampleCollector.sv ====
`timescale 1ns/1ps

module sampleCollector (
    input  logic                           clk,
    input  logic                           arstN,
    input  logic                           bitIn,
    output logic [firGeomPkg::DSR-1:0]     frame,
    output logic                           frameStb
);

    localparam int CNT_WIDTH = $clog2(firGeomPkg::DSR);
    localparam logic [CNT_WIDTH-1:0] LAST_COUNT = CNT_WIDTH'(firGeomPkg::DSR - 1);

    logic [CNT_WIDTH-1:0] count;
    logic [firGeomPkg::DSR-2:0] partial;
    logic frameDone;

    assign frameDone = (count == LAST_COUNT);

    // Position inside the current frame
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            count <= '0;
            frameStb <= 1'b0;
        end else begin
            frameStb <= frameDone;
            if (frameDone) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

    // Oldest bit ends up in the MSB
    always_ff @(posedge clk) begin
        partial <= {partial[firGeomPkg::DSR-3:0], bitIn};
        if (frameDone) begin
            frame <= {partial, bitIn};
        end
    end

    // Strobes are spaced by a whole frame
    frameSpacing: assert property (
        @(posedge clk) disable iff (!arstN)
        frameStb |=> (!frameStb) [*firGeomPkg::DSR-1]
    );

endmodule

// ==== historyShift.sv ====
`timescale 1ns/1ps

module historyShift (
    input  logic                                 clk,
    input  logic                                 arstN,
    input  logic [firGeomPkg::DSR-1:0]           frame,
    input  logic                                 frameStb,
    output logic [firGeomPkg::LOOKBACK-1:0]      lookback,
    output logic [firGeomPkg::LOOKAHEAD-1:0]     lookahead,
    output logic                                 winStb
);

    localparam int TOTAL = firGeomPkg::LOOKTOTAL;

    // Newest sample in bit 0, oldest in the MSB
    logic [TOTAL-1:0] window;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            window <= '0;
            winStb <= 1'b0;
        end else begin
            winStb <= frameStb;
            if (frameStb) begin
                window <= {window[TOTAL-firGeomPkg::DSR-1:0], frame};
            end
        end
    end

    // Older half already runs outward from the centre
    assign lookback = window[TOTAL-1:firGeomPkg::LOOKAHEAD];

    // Newer half reversed so bit 0 sits next to the centre
    for (genvar k = 0; k < firGeomPkg::LOOKAHEAD; k++) begin : gReverse
        assign lookahead[k] = window[firGeomPkg::LOOKAHEAD-1-k];
    end

endmodule

// ==== lutSumUnit.sv ====
`timescale 1ns/1ps

module lutSumUnit #(
    parameter int TAPS = 12
) (
    input  logic                                            clk,
    input  logic                                            arstN,
    input  logic [TAPS-1:0]                                 sel,
    input  logic signed [fxpFmtPkg::COEFF_WIDTH-1:0]        coeff [TAPS],
    input  logic                                            selStb,
    output logic signed [fxpFmtPkg::ACC_WIDTH-1:0]          sum,
    output logic                                            sumStb
);

    localparam int ACC_W = fxpFmtPkg::ACC_WIDTH;
    localparam int LUT_W = firGeomPkg::LUT_BITS;
    localparam int LUTS = TAPS / LUT_W;
    localparam int ENTRIES = 2 ** LUT_W;

    logic signed [ACC_W-1:0] lutTable [LUTS][ENTRIES];
    logic [LUT_W-1:0] lutAddr [LUTS];
    logic signed [ACC_W-1:0] lutOut [LUTS];
    logic signed [ACC_W-1:0] lutReg [LUTS];
    logic lutStb;
    logic signed [ACC_W-1:0] groupTotal;

    // Each entry is the sum of +c for a set bit and -c for a clear bit
    always_comb begin
        logic signed [ACC_W-1:0] entry;
        logic signed [ACC_W-1:0] tap;
        for (int g = 0; g < LUTS; g++) begin
            for (int a = 0; a < ENTRIES; a++) begin
                entry = '0;
                for (int b = 0; b < LUT_W; b++) begin
                    tap = ACC_W'(coeff[g*LUT_W+b]);
                    if (a[b]) begin
                        entry = entry + tap;
                    end else begin
                        entry = entry - tap;
                    end
                end
                lutTable[g][a] = entry;
            end
        end
    end

    // Address lookup per group
    for (genvar g = 0; g < LUTS; g++) begin : gLut
        assign lutAddr[g] = sel[g*LUT_W +: LUT_W];
        assign lutOut[g] = lutTable[g][lutAddr[g]];
    end

    always_comb begin
        groupTotal = '0;
        for (int g = 0; g < LUTS; g++) begin
            groupTotal = groupTotal + lutReg[g];
        end
    end

    // Strobe follows the data through both stages
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            lutStb <= 1'b0;
            sumStb <= 1'b0;
        end else begin
            lutStb <= selStb;
            sumStb <= lutStb;
        end
    end

    always_ff @(posedge clk) begin
        if (selStb) begin
            for (int g = 0; g < LUTS; g++) begin
                lutReg[g] <= lutOut[g];
            end
        end
        if (lutStb) begin
            sum <= groupTotal;
        end
    end

    // Two register stages between window and result
    sumLatency: assert property (
        @(posedge clk) disable iff (!arstN)
        sumStb == $past(selStb, 2)
    );

endmodule

// ==== outputFormat.sv ====
`timescale 1ns/1ps

module outputFormat (
    input  logic                                      clk,
    input  logic                                      arstN,
    input  logic signed [fxpFmtPkg::ACC_WIDTH-1:0]    aheadSum,
    input  logic signed [fxpFmtPkg::ACC_WIDTH-1:0]    backSum,
    input  logic                                      sumStb,
    output logic [fxpFmtPkg::OUT_WIDTH-1:0]           out,
    output logic                                      valid
);

    localparam int SUM_W = fxpFmtPkg::ACC_WIDTH + 1;
    localparam int SCALED_W = SUM_W - fxpFmtPkg::OUT_SHIFT;
    localparam int OUT_W = fxpFmtPkg::OUT_WIDTH;
    localparam logic signed [SCALED_W-1:0] MAX_OUT = SCALED_W'(2 ** (OUT_W - 1) - 1);
    localparam logic signed [SCALED_W-1:0] MIN_OUT = -SCALED_W'(2 ** (OUT_W - 1));
    localparam int FILL_W = $clog2(firGeomPkg::FRAMES_TO_FILL);
    localparam logic [FILL_W-1:0] LAST_FILL = FILL_W'(firGeomPkg::FRAMES_TO_FILL - 1);

    logic signed [SUM_W-1:0] total;
    logic signed [SUM_W-1:0] rounded;
    logic signed [SCALED_W-1:0] scaled;
    logic signed [OUT_W-1:0] clipped;
    logic [OUT_W-1:0] offsetCode;
    fxpFmtPkg::fillState_e state;
    logic [FILL_W-1:0] fillCount;

    assign total = SUM_W'(aheadSum) + SUM_W'(backSum);
    assign rounded = total + SUM_W'(fxpFmtPkg::ROUND_BIAS);
    assign scaled = rounded[SUM_W-1:fxpFmtPkg::OUT_SHIFT];

    always_comb begin
        if (scaled > MAX_OUT) begin
            clipped = MAX_OUT[OUT_W-1:0];
        end else if (scaled < MIN_OUT) begin
            clipped = MIN_OUT[OUT_W-1:0];
        end else begin
            clipped = scaled[OUT_W-1:0];
        end
    end

    // Two's complement to offset binary
    assign offsetCode = {~clipped[OUT_W-1], clipped[OUT_W-2:0]};

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            out <= '0;
            state <= fxpFmtPkg::FILLING;
            fillCount <= '0;
        end else if (sumStb) begin
            out <= offsetCode;
            if (state == fxpFmtPkg::FILLING) begin
                if (fillCount == LAST_FILL) begin
                    state <= fxpFmtPkg::RUNNING;
                end else begin
                    fillCount <= fillCount + 1'b1;
                end
            end
        end
    end

    assign valid = (state == fxpFmtPkg::RUNNING);

    // Only a reset takes valid away
    validHolds: assert property (
        @(posedge clk) disable iff (!arstN)
        !$fell(valid)
    );

endmodule

// ==== firDecimator.sv ====
`timescale 1ns/1ps

module firDecimator (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                bitIn,
    output logic [fxpFmtPkg::OUT_WIDTH-1:0]     out,
    output logic                                valid
);

    logic [firGeomPkg::DSR-1:0] frame;
    logic frameStb;
    logic [firGeomPkg::LOOKBACK-1:0] lookback;
    logic [firGeomPkg::LOOKAHEAD-1:0] lookahead;
    logic winStb;
    logic signed [fxpFmtPkg::ACC_WIDTH-1:0] aheadSum;
    logic signed [fxpFmtPkg::ACC_WIDTH-1:0] backSum;
    logic backStb;

    sampleCollector i_sampleCollector (
        .clk      (clk),
        .arstN    (arstN),
        .bitIn    (bitIn),
        .frame    (frame),
        .frameStb (frameStb)
    );

    historyShift i_historyShift (
        .clk       (clk),
        .arstN     (arstN),
        .frame     (frame),
        .frameStb  (frameStb),
        .lookback  (lookback),
        .lookahead (lookahead),
        .winStb    (winStb)
    );

    // Both halves run in lockstep, so one strobe is enough downstream
    lutSumUnit #(.TAPS(firGeomPkg::LOOKAHEAD)) i_aheadLut (
        .clk    (clk),
        .arstN  (arstN),
        .sel    (lookahead),
        .coeff  (firGeomPkg::HB),
        .selStb (winStb),
        .sum    (aheadSum),
        .sumStb ()
    );

    lutSumUnit #(.TAPS(firGeomPkg::LOOKBACK)) i_backLut (
        .clk    (clk),
        .arstN  (arstN),
        .sel    (lookback),
        .coeff  (firGeomPkg::HF),
        .selStb (winStb),
        .sum    (backSum),
        .sumStb (backStb)
    );

    outputFormat i_outputFormat (
        .clk      (clk),
        .arstN    (arstN),
        .aheadSum (aheadSum),
        .backSum  (backSum),
        .sumStb   (backStb),
        .out      (out),
        .valid    (valid)
    );

endmodule

// ==== firChecker.sv ====
`timescale 1ns/1ps

module firChecker (
    input  logic                              clk,
    input  logic                              arstN,
    input  logic                              bitIn,
    input  logic [fxpFmtPkg::OUT_WIDTH-1:0]   out,
    input  logic                              valid
);

    localparam int DSR = firGeomPkg::DSR;
    localparam int TOTAL = firGeomPkg::LOOKTOTAL;
    localparam int AHEAD = firGeomPkg::LOOKAHEAD;
    localparam int OUT_W = fxpFmtPkg::OUT_WIDTH;
    localparam int SHIFT = fxpFmtPkg::OUT_SHIFT;
    localparam int MAX_CODE = 2 ** (OUT_W - 1) - 1;
    localparam int MIN_CODE = -(2 ** (OUT_W - 1));

    typedef struct packed {
        int due;
        logic [OUT_W-1:0] expOut;
        logic fill;
        logic last;
        int testNo;
    } pendingCheck_t;

    // Test list as announced by the testbench
    string names [$];
    int framesOf [$];
    bit hasExpOf [$];
    logic [OUT_W-1:0] expOf [$];

    // Model state, rising edge only
    pendingCheck_t pending [$];
    logic [TOTAL-1:0] window;
    int clkCount;
    int frameCount;
    int frameInTest;
    int curTest = -1;

    // Result state, falling edge only
    bit expValid;
    bit inReset;
    int resetTest;
    int testChecks;
    int testErrs;
    int totalChecks;
    int totalErrs;
    int reported;

    task automatic beginTest(string name, int frames, bit hasExp, logic [OUT_W-1:0] expOut);
        names.push_back(name);
        framesOf.push_back(frames);
        hasExpOf.push_back(hasExp);
        expOf.push_back(expOut);
    endtask

    // Samples weigh +1 or -1, newest sample in bit 0
    function automatic logic [OUT_W-1:0] expectedOut(logic [TOTAL-1:0] win);
        int total;
        int scaled;
        logic [OUT_W-1:0] code;
        total = 0;
        for (int k = 0; k < AHEAD; k++) begin
            total += win[AHEAD-1-k] ? int'(firGeomPkg::HB[k]) : -int'(firGeomPkg::HB[k]);
        end
        for (int k = 0; k < firGeomPkg::LOOKBACK; k++) begin
            total += win[AHEAD+k] ? int'(firGeomPkg::HF[k]) : -int'(firGeomPkg::HF[k]);
        end
        scaled = (total + (1 << (SHIFT - 1))) >>> SHIFT;
        if (scaled > MAX_CODE) begin
            scaled = MAX_CODE;
        end else if (scaled < MIN_CODE) begin
            scaled = MIN_CODE;
        end
        code = OUT_W'(scaled);
        code[OUT_W-1] = ~code[OUT_W-1];
        return code;
    endfunction

    task automatic countCheck();
        testChecks++;
        totalChecks++;
    endtask

    task automatic noteError();
        testErrs++;
        totalErrs++;
    endtask

    task automatic closeTest(string name, string note);
        $display("%s: %s, %0d checks, %0d errors", name, note, testChecks, testErrs);
        testChecks = 0;
        testErrs = 0;
        reported++;
    endtask

    task automatic printTotals();
        $display("tests %0d, checks %0d, errors %0d", reported, totalChecks, totalErrs);
    endtask

    always @(posedge clk) begin
        int idx;
        pendingCheck_t item;
        if (!arstN) begin
            window = '0;
            clkCount = 0;
            frameCount = 0;
            frameInTest = 0;
            pending.delete();
        end else begin
            idx = clkCount;
            while (pending.size() > 0 && pending[0].due < idx) begin
                pending.delete(0);
            end
            // New tests only start on a frame boundary
            if (idx % DSR == 0 && curTest != names.size() - 1) begin
                curTest = names.size() - 1;
                frameInTest = 0;
            end
            window = {window[TOTAL-2:0], bitIn};
            if (idx % DSR == DSR - 1) begin
                frameCount++;
                frameInTest++;
                item.due = idx + firGeomPkg::PIPE_FRAMES;
                if (hasExpOf[curTest] && frameInTest >= firGeomPkg::FRAMES_TO_FILL) begin
                    item.expOut = expOf[curTest];
                end else begin
                    item.expOut = expectedOut(window);
                end
                item.fill = (frameCount >= firGeomPkg::FRAMES_TO_FILL);
                item.last = (frameInTest == framesOf[curTest]);
                item.testNo = curTest;
                pending.push_back(item);
            end
            clkCount++;
        end
    end

    always @(negedge clk) begin
        pendingCheck_t item;
        if (!arstN) begin
            if (!inReset) begin
                inReset = 1'b1;
                resetTest = names.size() - 1;
                // Last word of the previous test never comes out
                if (pending.size() > 0) begin
                    closeTest(names[pending[0].testNo], "cut short by reset");
                end
            end
            expValid = 1'b0;
            countCheck();
            if (out !== '0 || valid !== 1'b0) begin
                $display("%s: out or valid not cleared during reset", names[resetTest]);
                noteError();
            end
        end else begin
            if (inReset) begin
                inReset = 1'b0;
                closeTest(names[resetTest], "done");
            end
            if (pending.size() > 0 && pending[0].due == clkCount - 1) begin
                item = pending[0];
                if (item.fill) begin
                    expValid = 1'b1;
                end
                if (expValid) begin
                    countCheck();
                    if (out !== item.expOut) begin
                        $display("mismatch %s expected %h actual %h",
                                 names[item.testNo], item.expOut, out);
                        noteError();
                    end
                end
                if (item.last) begin
                    closeTest(names[item.testNo], "done");
                end
            end
            if (valid !== expValid) begin
                $display("%s: valid is %b where %b was expected",
                         names[names.size()-1], valid, expValid);
                noteError();
            end
        end
    end

endmodule

// ==== tbFirDecimator.sv ====
`timescale 1ns/1ps

module tbFirDecimator;

    localparam int DSR = firGeomPkg::DSR;
    localparam int OUT_W = fxpFmtPkg::OUT_WIDTH;
    localparam int RESET_CYCLES = 8;
    localparam int PERIOD_NS = 100;

    typedef enum {
        RESET,
        ZEROS,
        ONES,
        ALTERNATING,
        IMPULSE,
        RANDOM
    } patternKind_e;

    logic clk;
    logic arstN;
    logic bitIn;
    logic [OUT_W-1:0] out;
    logic valid;

    string testName [$];
    patternKind_e testKind [$];
    int testArg [$];
    int testFrames [$];
    bit testHasExp [$];
    logic [OUT_W-1:0] testExp [$];

    firDecimator i_firDecimator (
        .clk   (clk),
        .arstN (arstN),
        .bitIn (bitIn),
        .out   (out),
        .valid (valid)
    );

    firChecker i_firChecker (
        .clk   (clk),
        .arstN (arstN),
        .bitIn (bitIn),
        .out   (out),
        .valid (valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    task automatic addEntry(string name, patternKind_e kind, int arg, int frames,
                            bit hasExp, logic [OUT_W-1:0] expOut);
        testName.push_back(name);
        testKind.push_back(kind);
        testArg.push_back(arg);
        testFrames.push_back(frames);
        testHasExp.push_back(hasExp);
        testExp.push_back(expOut);
    endtask

    task automatic buildTable();
        addEntry("powerOnReset", RESET, 0, 0, 1'b0, '0);
        addEntry("zerosFill", ZEROS, 0, 10, 1'b1, 12'h000);
        addEntry("onesSaturate", ONES, 0, 10, 1'b1, 12'hfff);
        // Window sum is -100, which rounds up to zero, the mid code
        addEntry("alternating", ALTERNATING, 0, 10, 1'b1, 12'h800);
        addEntry("zerosSaturate", ZEROS, 0, 8, 1'b1, 12'h000);
        // Offsets 4 to 7 together put the 1 on all 24 taps
        addEntry("impulse4", IMPULSE, 4, 8, 1'b0, '0);
        addEntry("impulse5", IMPULSE, 5, 8, 1'b0, '0);
        addEntry("impulse6", IMPULSE, 6, 8, 1'b0, '0);
        addEntry("impulse7", IMPULSE, 7, 8, 1'b0, '0);
        addEntry("random", RANDOM, 0, 20, 1'b0, '0);
        addEntry("midRunReset", RESET, 0, 0, 1'b0, '0);
        addEntry("randomRefill", RANDOM, 0, 12, 1'b0, '0);
    endtask

    function automatic logic patternBit(patternKind_e kind, int arg, int pos);
        case (kind)
            ONES: return 1'b1;
            ALTERNATING: return (pos % 2 == 0);
            IMPULSE: return (pos == arg);
            RANDOM: return 1'($urandom());
            default: return 1'b0;
        endcase
    endfunction

    task automatic applyReset();
        arstN <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;
    endtask

    // Each bit is set on one edge and sampled by the DUT on the next
    task automatic applyPattern(int n);
        for (int j = 0; j < testFrames[n] * DSR; j++) begin
            bitIn <= patternBit(testKind[n], testArg[n], j);
            @(posedge clk);
        end
    endtask

    initial begin
        int cycles;
        arstN = 1'b0;
        bitIn = 1'b0;
        void'($urandom(32'hfd58));
        buildTable();
        cycles = 50;
        foreach (testName[n]) begin
            if (testKind[n] == RESET) begin
                cycles += RESET_CYCLES;
            end else begin
                cycles += testFrames[n] * DSR;
            end
        end
        fork
            begin
                #(cycles * PERIOD_NS);
                $display("timeout: run still going after %0d clock cycles", cycles);
                $display("TESTS FAILED");
                $finish;
            end
        join_none
        foreach (testName[n]) begin
            i_firChecker.beginTest(testName[n], testFrames[n], testHasExp[n], testExp[n]);
            if (testKind[n] == RESET) begin
                applyReset();
            end else begin
                applyPattern(n);
            end
        end
        // Last words are still in the pipeline
        while (i_firChecker.reported < testName.size()) begin
            @(posedge clk);
        end
        i_firChecker.printTotals();
        if (i_firChecker.totalErrs == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
fxpFmtPkg.sv
firGeomPkg.sv
sampleCollector.sv
historyShift.sv
lutSumUnit.sv
outputFormat.sv
firDecimator.sv
firChecker.sv
tbFirDecimator.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the FIR decimator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module tbFirDecimator -o simFir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simFir > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1
